// File: hw/fetch_consts.svh
// Fetch stage constants
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////
// Datapath widths
////////////////////////////////

// Address and instruction word width
`define FETCH_ADDR_W 32

////////////////////////////////
// Buffering limits
////////////////////////////////

// Entries in the instruction buffer
`define FETCH_FIFO_DEPTH 3
// Accepted bus requests still waiting for a response
`define FETCH_MAX_OUTSTANDING 2
// Width of buffer and outstanding counters
`define FETCH_CNT_W 2

// Trap vector base, upper address bits only
`define MTVEC_BASE_W 25
// Interrupt index used for vectored traps
`define IRQ_INDEX_W 5

`endif

// File: hw/fetch_pkg.sv
// Fetch stage types
`include "fetch_consts.svh"

package fetch_pkg;

  ////////////////////////////////
  // Redirect sources
  ////////////////////////////////

  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_DBD = 4'd7,
    PC_TRAP_DBE = 4'd8
  } pc_mux_e;

  // Controller requests towards IF
  typedef struct packed {
    logic                    pc_set;
    pc_mux_e                 pc_mux;
    logic [`IRQ_INDEX_W-1:0] irq_index;
    logic                    kill_if;
    logic                    halt_if;
  } ctrl_fsm_t;

  // Candidate redirect addresses from the rest of the core
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] boot;
    logic [`FETCH_ADDR_W-1:0] jump;
    logic [`FETCH_ADDR_W-1:0] branch;
    logic [`FETCH_ADDR_W-1:0] mepc;
    logic [`FETCH_ADDR_W-1:0] dpc;
    logic [`FETCH_ADDR_W-1:0] dm_halt;
    logic [`FETCH_ADDR_W-1:0] dm_exception;
  } redirect_targets_t;

  ////////////////////////////////
  // Instruction bus
  ////////////////////////////////

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] rdata;
    logic                     err;
  } fetch_resp_t;

  // One buffered word, tagged with its fetch address
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [`FETCH_ADDR_W-1:0] rdata;
    logic                     err;
  } fetch_entry_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic                     instr_valid;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_ADDR_W-1:0] instr;
    logic                     bus_err;
    logic                     abort_op;
  } if_id_pipe_t;

endpackage

// File: hw/pc_select.sv
// Next PC selection
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_select (
  input  fetch_pkg::ctrl_fsm_t         ctrl_i,
  input  fetch_pkg::redirect_targets_t targets_i,
  input  logic [`MTVEC_BASE_W-1:0]     mtvec_addr_i,
  output logic [`FETCH_ADDR_W-1:0]     branch_addr_o,
  output logic                         csr_mtvec_init_o
);

  import fetch_pkg::*;

  // Raw target before word alignment
  logic [`FETCH_ADDR_W-1:0] target_raw;

  ////////////////////////////////
  // Target multiplexer
  ////////////////////////////////

  always_comb begin
    unique case (ctrl_i.pc_mux)
      PC_BOOT:     target_raw = targets_i.boot;
      PC_JUMP:     target_raw = targets_i.jump;
      PC_BRANCH:   target_raw = targets_i.branch;
      // Return from trap restores the saved PC
      PC_MRET:     target_raw = targets_i.mepc;
      // Return from debug mode
      PC_DRET:     target_raw = targets_i.dpc;
      // All exceptions share the vector base
      PC_TRAP_EXC: target_raw = {mtvec_addr_i, 7'b000_0000};
      // Interrupts are vectored by index
      PC_TRAP_IRQ: target_raw = {mtvec_addr_i, ctrl_i.irq_index, 2'b00};
      // Debug entry
      PC_TRAP_DBD: target_raw = targets_i.dm_halt;
      // Exception while in debug mode
      PC_TRAP_DBE: target_raw = targets_i.dm_exception;
      default:     target_raw = targets_i.boot;
    endcase
  end

  // Only aligned words are fetched
  assign branch_addr_o = {target_raw[`FETCH_ADDR_W-1:2], 2'b00};

  ////////////////////////////////
  // Trap vector init
  ////////////////////////////////

  // CSR file loads mtvec on the boot redirect
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

endmodule

// File: hw/prefetch_ctrl.sv
// Instruction prefetcher
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
  input  logic [`FETCH_CNT_W-1:0]  fifo_cnt_i,
  output logic                     bus_req_valid_o,
  input  logic                     bus_req_ready_i,
  output fetch_pkg::fetch_req_t    bus_req_o,
  input  logic                     bus_resp_valid_i,
  input  fetch_pkg::fetch_resp_t   bus_resp_i,
  output logic                     push_o,
  output fetch_pkg::fetch_entry_t  push_entry_o,
  output logic                     busy_o
);

  localparam int unsigned QPTR_W = $clog2(`FETCH_MAX_OUTSTANDING);
  localparam logic [QPTR_W-1:0] QPTR_LAST = QPTR_W'(`FETCH_MAX_OUTSTANDING - 1);

  // Fetching starts with the first redirect after reset
  logic                     fetch_en_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;
  logic [`FETCH_CNT_W-1:0]  out_cnt_q;
  // Responses still owed to requests from before the last redirect
  logic [`FETCH_CNT_W-1:0]  discard_q;
  // Addresses of accepted requests, oldest at the read pointer
  logic [`FETCH_ADDR_W-1:0] inflight_q [`FETCH_MAX_OUTSTANDING];
  logic [QPTR_W-1:0]        inflight_wr_q;
  logic [QPTR_W-1:0]        inflight_rd_q;
  logic [`FETCH_CNT_W:0]    occupancy;
  logic                     req_accept;
  logic                     resp_stale;

  ////////////////////////////////
  // Request side
  ////////////////////////////////

  // Words in flight plus words already buffered
  assign occupancy = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_i};

  // Hold off during the redirect cycle so no old address slips out
  assign bus_req_valid_o = fetch_en_q && !pc_set_i &&
                           (out_cnt_q < `FETCH_MAX_OUTSTANDING) &&
                           (occupancy < `FETCH_FIFO_DEPTH);

  assign bus_req_o  = '{addr: addr_q};
  assign req_accept = bus_req_valid_o && bus_req_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q <= 1'b0;
      addr_q     <= '0;
    end else if (pc_set_i) begin
      fetch_en_q <= 1'b1;
      addr_q     <= branch_addr_i;
    end else if (req_accept) begin
      // Sequential word fetch
      addr_q <= addr_q + `FETCH_ADDR_W'(4);
    end
  end

  // Outstanding count, one up per accept and one down per response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= '0;
    end else begin
      unique case ({req_accept, bus_resp_valid_i})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  ////////////////////////////////
  // Response side
  ////////////////////////////////

  // A response in the redirect cycle is already stale
  assign resp_stale = pc_set_i || (discard_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      discard_q <= '0;
    end else if (pc_set_i) begin
      // Everything still in flight belongs to the old stream
      discard_q <= out_cnt_q - {{(`FETCH_CNT_W-1){1'b0}}, bus_resp_valid_i};
    end else if (bus_resp_valid_i && (discard_q != '0)) begin
      discard_q <= discard_q - 1'b1;
    end
  end

  // In-flight address queue pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight_wr_q <= '0;
      inflight_rd_q <= '0;
    end else begin
      if (req_accept) begin
        inflight_wr_q <= (inflight_wr_q == QPTR_LAST) ? '0 : inflight_wr_q + 1'b1;
      end
      // Every response retires one entry, stale or not
      if (bus_resp_valid_i) begin
        inflight_rd_q <= (inflight_rd_q == QPTR_LAST) ? '0 : inflight_rd_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      inflight_q[inflight_wr_q] <= addr_q;
    end
  end

  assign push_o       = bus_resp_valid_i && !resp_stale;
  assign push_entry_o = '{addr:  inflight_q[inflight_rd_q],
                          rdata: bus_resp_i.rdata,
                          err:   bus_resp_i.err};

  assign busy_o = (out_cnt_q != '0);

endmodule

// File: hw/fetch_fifo.sv
// Fetched instruction buffer
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t entry_i,
  input  logic                    pop_i,
  output fetch_pkg::fetch_entry_t head_o,
  output logic                    not_empty_o,
  output logic [`FETCH_CNT_W-1:0] cnt_o
);

  import fetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(`FETCH_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`FETCH_FIFO_DEPTH - 1);

  fetch_entry_t            mem_q [`FETCH_FIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [`FETCH_CNT_W-1:0] cnt_q;
  logic                    do_push;
  logic                    do_pop;

  // Flush wins over both ports
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && not_empty_o && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      unique case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (cnt_q != '0);
  assign cnt_o       = cnt_q;

endmodule

// File: hw/if_id_pipe.sv
// IF/ID pipeline register
`timescale 1ns/1ps
`include "fetch_consts.svh"

module if_id_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_pkg::ctrl_fsm_t     ctrl_i,
  input  fetch_pkg::fetch_entry_t  head_i,
  input  logic                     not_empty_i,
  output logic                     pop_o,
  input  logic                     trigger_match_i,
  input  logic                     id_ready_i,
  output logic                     if_valid_o,
  output logic [`FETCH_ADDR_W-1:0] pc_if_o,
  output logic                     abort_op_o,
  output fetch_pkg::if_id_pipe_t   if_id_pipe_o
);

  logic                     if_ready;
  logic                     issue;
  logic                     instr_valid_q;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic [`FETCH_ADDR_W-1:0] instr_q;
  logic                     bus_err_q;
  logic                     abort_q;

  ////////////////////////////////
  // Stage handshake
  ////////////////////////////////

  // Killed or halted words never leave IF
  assign if_valid_o = not_empty_i && !ctrl_i.kill_if && !ctrl_i.halt_if;
  // Kill always drains, halt blocks
  assign if_ready   = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);
  assign issue      = if_valid_o && if_ready;
  assign pop_o      = issue;

  assign pc_if_o    = head_i.addr;
  // Known fault or trigger hit, ID must not execute it
  assign abort_op_o = head_i.err || trigger_match_i;

  ////////////////////////////////
  // Pipeline register
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (issue) begin
      instr_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // ID took its word and nothing new came
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      pc_q      <= head_i.addr;
      instr_q   <= head_i.rdata;
      bus_err_q <= head_i.err;
      abort_q   <= abort_op_o;
    end
  end

  assign if_id_pipe_o = '{instr_valid: instr_valid_q,
                          pc:          pc_q,
                          instr:       instr_q,
                          bus_err:     bus_err_q,
                          abort_op:    abort_q};

endmodule

// File: hw/if_stage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`include "fetch_consts.svh"

module if_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fetch_pkg::ctrl_fsm_t         ctrl_i,
  input  fetch_pkg::redirect_targets_t targets_i,
  input  logic [`MTVEC_BASE_W-1:0]     mtvec_addr_i,
  input  logic                         trigger_match_i,
  input  logic                         id_ready_i,
  // Instruction bus
  output logic                         bus_req_valid_o,
  input  logic                         bus_req_ready_i,
  output fetch_pkg::fetch_req_t        bus_req_o,
  input  logic                         bus_resp_valid_i,
  input  fetch_pkg::fetch_resp_t       bus_resp_i,
  // Stage outputs
  output logic                         if_valid_o,
  output logic [`FETCH_ADDR_W-1:0]     pc_if_o,
  output logic                         abort_op_o,
  output logic                         if_busy_o,
  output logic                         csr_mtvec_init_o,
  output fetch_pkg::if_id_pipe_t       if_id_pipe_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic [`FETCH_CNT_W-1:0]  fifo_cnt;
  logic                     fifo_push;
  fetch_entry_t             fifo_entry;
  fetch_entry_t             fifo_head;
  logic                     fifo_not_empty;
  logic                     fifo_pop;

  ////////////////////////////////
  // Redirect target
  ////////////////////////////////

  pc_select u_pc_select (
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // Bus master, tags responses and drops stale ones
  prefetch_ctrl u_prefetch_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (ctrl_i.pc_set),
    .branch_addr_i    (branch_addr),
    .fifo_cnt_i       (fifo_cnt),
    .bus_req_valid_o  (bus_req_valid_o),
    .bus_req_ready_i  (bus_req_ready_i),
    .bus_req_o        (bus_req_o),
    .bus_resp_valid_i (bus_resp_valid_i),
    .bus_resp_i       (bus_resp_i),
    .push_o           (fifo_push),
    .push_entry_o     (fifo_entry),
    .busy_o           (if_busy_o)
  );

  // Emptied on every redirect
  fetch_fifo u_fetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (ctrl_i.pc_set),
    .push_i      (fifo_push),
    .entry_i     (fifo_entry),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .cnt_o       (fifo_cnt)
  );

  ////////////////////////////////
  // Hand-off to ID
  ////////////////////////////////

  if_id_pipe u_if_id_pipe (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_i          (ctrl_i),
    .head_i          (fifo_head),
    .not_empty_i     (fifo_not_empty),
    .pop_o           (fifo_pop),
    .trigger_match_i (trigger_match_i),
    .id_ready_i      (id_ready_i),
    .if_valid_o      (if_valid_o),
    .pc_if_o         (pc_if_o),
    .abort_op_o      (abort_op_o),
    .if_id_pipe_o    (if_id_pipe_o)
  );

endmodule

// File: sim/tb_instr_mem.sv
// Instruction memory model
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_instr_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  fetch_pkg::fetch_req_t  req_i,
  output logic                   resp_valid_o,
  output fetch_pkg::fetch_resp_t resp_o,
  output int unsigned            out_cnt_o
);

  import fetch_pkg::*;

  // Accepted addresses and the cycle each response is due
  logic [`FETCH_ADDR_W-1:0] addr_q [$];
  longint unsigned          due_q [$];
  longint unsigned          cyc;
  longint unsigned          last_due;

  // Data is a fixed pattern of the address, errors in one window
  function automatic fetch_resp_t read_word(input logic [`FETCH_ADDR_W-1:0] addr);
    fetch_resp_t r;
    r.rdata = addr ^ 32'h5A5A_0000;
    r.err   = (addr >= 32'h0000_F000) && (addr <= 32'h0000_F0FF);
    return r;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    int unsigned     lat;
    longint unsigned due;
    if (!rst_n) begin
      req_ready_o  <= 1'b0;
      resp_valid_o <= 1'b0;
      resp_o       <= '0;
      out_cnt_o    <= 0;
      addr_q.delete();
      due_q.delete();
      cyc      = 0;
      last_due = 0;
    end else begin
      cyc = cyc + 1;
      // Unanswered requests as the master sees them after this edge
      out_cnt_o <= out_cnt_o + int'(req_valid_i && req_ready_o) - int'(resp_valid_o);
      // Oldest response first, at most one per cycle
      if ((due_q.size() > 0) && (due_q[0] <= cyc)) begin
        resp_valid_o <= 1'b1;
        resp_o       <= read_word(addr_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        resp_valid_o <= 1'b0;
        resp_o       <= '0;
      end
      if (req_valid_i && req_ready_o) begin
        lat = 1 + ($urandom % 4);
        due = cyc + lat;
        // Keep responses in order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        addr_q.push_back(req_i.addr);
        due_q.push_back(due);
        last_due = due;
      end
      // random stalls on the request channel
      req_ready_o <= ($urandom % 3) != 0;
    end
  end

endmodule

// File: sim/tb_if_stage.sv
// Fetch stage testbench
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_if_stage;

  import fetch_pkg::*;

  logic                     clk;
  logic                     rst_n;
  ctrl_fsm_t                ctrl;
  redirect_targets_t        targets;
  logic [`MTVEC_BASE_W-1:0] mtvec;
  logic                     trigger_match;
  logic                     id_ready;
  logic                     req_valid;
  logic                     req_ready;
  fetch_req_t               req;
  logic                     resp_valid;
  fetch_resp_t              resp;
  logic                     if_valid;
  logic [31:0]              pc_if;
  logic                     abort_op;
  logic                     if_busy;
  logic                     csr_mtvec_init;
  if_id_pipe_t              pipe;
  int unsigned              mem_out_cnt;
  // Background randomization of ID ready and triggers
  logic                     rand_ready_en;
  logic                     rand_trig_en;
  // Reference model state
  logic [31:0]              exp_pc;
  int unsigned              issue_cnt;
  int unsigned              err_issue_cnt;
  int unsigned              trig_issue_cnt;
  logic                     pend_chk;
  logic                     pend_clear;
  logic                     pend_hold;
  logic [31:0]              pend_pc;
  logic                     pend_trig;
  if_id_pipe_t              hold_snap;

  always #50 clk = ~clk;

  if_stage DUT (
    .clk (clk), .rst_n (rst_n), .ctrl_i (ctrl), .targets_i (targets),
    .mtvec_addr_i (mtvec), .trigger_match_i (trigger_match), .id_ready_i (id_ready),
    .bus_req_valid_o (req_valid), .bus_req_ready_i (req_ready), .bus_req_o (req),
    .bus_resp_valid_i (resp_valid), .bus_resp_i (resp),
    .if_valid_o (if_valid), .pc_if_o (pc_if), .abort_op_o (abort_op), .if_busy_o (if_busy),
    .csr_mtvec_init_o (csr_mtvec_init), .if_id_pipe_o (pipe)
  );

  tb_instr_mem u_instr_mem (
    .clk (clk), .rst_n (rst_n), .req_valid_i (req_valid), .req_ready_o (req_ready),
    .req_i (req), .resp_valid_o (resp_valid), .resp_o (resp), .out_cnt_o (mem_out_cnt)
  );

  //////////////////////////////
  // Model helpers
  //////////////////////////////

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= 32'h0000_F000) && (addr <= 32'h0000_F0FF);
  endfunction

  // Redirect address from the source rules
  function automatic logic [31:0] expected_target(input ctrl_fsm_t c,
                                                  input redirect_targets_t t,
                                                  input logic [`MTVEC_BASE_W-1:0] base);
    logic [31:0] a;
    case (c.pc_mux)
      PC_JUMP:     a = t.jump;
      PC_BRANCH:   a = t.branch;
      PC_MRET:     a = t.mepc;
      PC_DRET:     a = t.dpc;
      PC_TRAP_EXC: a = {base, 7'd0};
      PC_TRAP_IRQ: a = {base, c.irq_index, 2'b00};
      PC_TRAP_DBD: a = t.dm_halt;
      PC_TRAP_DBE: a = t.dm_exception;
      default:     a = t.boot;
    endcase
    a[1:0] = 2'b00;
    return a;
  endfunction

  // Mostly low memory, sometimes inside the error window
  function automatic logic [31:0] rand_addr();
    if (($urandom % 4) == 0) begin
      return 32'h0000_F000 | ($urandom & 32'hFF);
    end
    return $urandom & 32'h0001_FFFF;
  endfunction

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check(input string name, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // One-cycle pc_set paired with kill_if, fresh random targets
  task automatic redirect(input pc_mux_e kind);
    @(posedge clk);
    targets <= '{boot: rand_addr(), jump: rand_addr(), branch: rand_addr(),
                 mepc: rand_addr(), dpc: rand_addr(), dm_halt: rand_addr(),
                 dm_exception: rand_addr()};
    mtvec   <= `MTVEC_BASE_W'($urandom);
    ctrl    <= '{pc_set: 1'b1, pc_mux: kind, irq_index: `IRQ_INDEX_W'($urandom),
                 kill_if: 1'b1, halt_if: 1'b0};
    @(posedge clk);
    ctrl <= '0;
  endtask

  task automatic jump_to(input logic [31:0] addr);
    @(posedge clk);
    targets.jump <= addr;
    ctrl         <= '{pc_set: 1'b1, pc_mux: PC_JUMP, irq_index: '0, kill_if: 1'b1, halt_if: 1'b0};
    @(posedge clk);
    ctrl <= '0;
  endtask

  task automatic wait_issues(input int unsigned n);
    int unsigned target;
    int unsigned cycles;
    target = issue_cnt + n;
    cycles = 0;
    while (issue_cnt < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > 100 * n + 50) begin
        $display("Timeout waiting for issues, %0d of %0d seen", issue_cnt + n - target, n);
        abort_run();
      end
    end
  endtask

  // Random ID back-pressure and trigger hits
  always @(posedge clk) begin
    if (rand_ready_en) begin
      id_ready <= ($urandom % 4) != 0;
    end
    if (rand_trig_en) begin
      trigger_match <= ($urandom % 8) == 0;
    end
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      check("csr_mtvec_init_o", csr_mtvec_init, ctrl.pc_set && (ctrl.pc_mux == PC_BOOT));
      if (mem_out_cnt > `FETCH_MAX_OUTSTANDING) begin
        $display("Memory saw %0d requests unanswered, limit is %0d", mem_out_cnt,
                 `FETCH_MAX_OUTSTANDING);
        abort_run();
      end
      // Busy while the memory still owes a response
      check("if_busy_o", if_busy, mem_out_cnt != 0);
      if (ctrl.halt_if) begin
        check("if_valid_o", if_valid, 1'b0);
      end
      // Register contents after the last edge
      if (pend_chk) begin
        check("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b1);
        check("if_id_pipe_o.pc", pipe.pc, pend_pc);
        check("if_id_pipe_o.instr", pipe.instr, pend_pc ^ 32'h5A5A_0000);
        check("if_id_pipe_o.bus_err", pipe.bus_err, in_err_window(pend_pc));
        check("if_id_pipe_o.abort_op", pipe.abort_op, in_err_window(pend_pc) || pend_trig);
        if (in_err_window(pend_pc)) begin
          err_issue_cnt++;
        end else if (pend_trig) begin
          trig_issue_cnt++;
        end
      end else if (pend_clear) begin
        check("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b0);
      end else if (pend_hold) begin
        check("if_id_pipe_o", pipe, hold_snap);
      end
      pend_chk   = 1'b0;
      pend_clear = 1'b0;
      pend_hold  = 1'b0;
      if (ctrl.pc_set) begin
        exp_pc = expected_target(ctrl, targets, mtvec);
      end
      if (if_valid && id_ready) begin
        check("pc_if_o", pc_if, exp_pc);
        check("abort_op_o", abort_op, in_err_window(exp_pc) || trigger_match);
        pend_chk  = 1'b1;
        pend_pc   = exp_pc;
        pend_trig = trigger_match;
        exp_pc    = exp_pc + 32'd4;
        issue_cnt++;
      end else if (id_ready) begin
        pend_clear = 1'b1;
      end else begin
        pend_hold = 1'b1;
        hold_snap = pipe;
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'he830));
    clk            = 1'b0;
    rst_n          = 1'b0;
    ctrl           = '0;
    targets        = '0;
    mtvec          = '0;
    trigger_match  = 1'b0;
    id_ready       = 1'b0;
    rand_ready_en  = 1'b0;
    rand_trig_en   = 1'b0;
    exp_pc         = '0;
    issue_cnt      = 0;
    err_issue_cnt  = 0;
    trig_issue_cnt = 0;
    pend_chk       = 1'b0;
    pend_clear     = 1'b0;
    pend_hold      = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("bus_req_valid_o", req_valid, 1'b0);
    check("if_valid_o", if_valid, 1'b0);
    check("if_busy_o", if_busy, 1'b0);
    check("if_id_pipe_o.instr_valid", pipe.instr_valid, 1'b0);

    // Boot stream with ID always ready
    @(posedge clk);
    id_ready <= 1'b1;
    redirect(PC_BOOT);
    wait_issues(8);

    // Random redirects under back-pressure and triggers
    @(posedge clk);
    rand_ready_en <= 1'b1;
    rand_trig_en  <= 1'b1;
    for (int i = 0; i < 60; i++) begin
      redirect(pc_mux_e'($urandom % 9));
      if (($urandom % 4) == 0) begin
        repeat (1 + $urandom % 3) @(posedge clk);
      end else begin
        wait_issues(1 + $urandom % 6);
      end
    end
    @(posedge clk);
    rand_ready_en <= 1'b0;
    rand_trig_en  <= 1'b0;
    @(posedge clk);
    id_ready      <= 1'b1;
    trigger_match <= 1'b0;

    // Halt holds the PC and blocks issue
    wait_issues(2);
    @(posedge clk);
    ctrl.halt_if <= 1'b1;
    repeat (10) @(posedge clk);
    ctrl.halt_if <= 1'b0;
    wait_issues(4);

    // Across the end of the error window, then trigger hits
    jump_to(32'h0000_F0F0);
    wait_issues(6);
    @(posedge clk);
    trigger_match <= 1'b1;
    wait_issues(2);
    @(posedge clk);
    trigger_match <= 1'b0;
    wait_issues(2);
    repeat (2) @(posedge clk);

    if (err_issue_cnt == 0) begin
      $display("No word from the error window was issued");
      abort_run();
    end else if (trig_issue_cnt == 0) begin
      $display("No trigger abort without a bus error was issued");
      abort_run();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+hw
hw/fetch_pkg.sv
hw/pc_select.sv
hw/prefetch_ctrl.sv
hw/fetch_fifo.sv
hw/if_id_pipe.sv
hw/if_stage.sv
sim/tb_instr_mem.sv
sim/tb_if_stage.sv

// File: Bender.yml
package:
  name: if_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/pc_select.sv
      - hw/prefetch_ctrl.sv
      - hw/fetch_fifo.sv
      - hw/if_id_pipe.sv
      - hw/if_stage.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_instr_mem.sv
      - sim/tb_if_stage.sv
